// File: fact_pkg.sv
`default_nettype none

package fact_pkg;

  localparam int OPND_W  = 4;
  localparam int PROD_W  = 32;
  localparam int N_LIMIT = 12; // 13! no longer fits in 32 bits.

  typedef struct packed {
    logic [OPND_W-1:0] n;
  } fact_req_t;

  typedef struct packed {
    logic [PROD_W-1:0] product;
    logic              err;
  } fact_rsp_t;

  // Next value of the product register.
  typedef enum logic [1:0] {
    MAC_HOLD = 2'b00,
    MAC_ONE  = 2'b01,
    MAC_MUL  = 2'b10,
    MAC_ZERO = 2'b11
  } mac_sel_t;

  // FSM to datapath control bundle.
  typedef struct packed {
    logic     cnt_load; // Counter takes the operand.
    logic     cnt_dec;  // Counter steps down by one.
    mac_sel_t mac_sel;
    logic     finish;   // Write the response buffer.
  } dp_ctrl_t;

endpackage

`default_nettype wire

// File: fact_count.sv
`timescale 1ns/1ps
`default_nettype none

module fact_count
  import fact_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire dp_ctrl_t    dp_ctrl,
  input  wire fact_req_t   req,
  output logic [OPND_W-1:0] count,
  output logic             cnt_more,
  output logic             over_limit
);

  fact_req_t req_q;

  // Operand as seen at the accept edge.
  always_ff @(posedge clk) begin
    req_q <= req;
  end

  // Load wins over decrement.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (dp_ctrl.cnt_load) begin
      count <= req_q.n;
    end else if (dp_ctrl.cnt_dec) begin
      count <= count - 1'b1;
    end
  end

  assign cnt_more   = (count > OPND_W'(1));      // Still factors left.
  assign over_limit = (count > OPND_W'(N_LIMIT)); // Result would overflow.

  // The FSM must stop stepping once the count reaches one.
  a_no_dec_at_end : assert property (
    @(posedge clk) disable iff (rst)
    dp_ctrl.cnt_dec |-> (count > OPND_W'(1))
  ) else $error("error: cnt_dec with count %h", count);

endmodule

`default_nettype wire

// File: fact_mac.sv
`timescale 1ns/1ps
`default_nettype none

module fact_mac
  import fact_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire dp_ctrl_t        dp_ctrl,
  input  wire [OPND_W-1:0]     count,
  output logic [PROD_W-1:0]    product
);

  logic [PROD_W+OPND_W-1:0] mul_full;
  logic [PROD_W-1:0]        mul_res;
  logic [PROD_W-1:0]        prod_nxt;

  assign mul_full = (PROD_W+OPND_W)'(product) * (PROD_W+OPND_W)'(count);

  // Upper bits dropped; the operand never exceeds the limit here.
  assign mul_res = mul_full[PROD_W-1:0];

  always_comb begin
    case (dp_ctrl.mac_sel)
      MAC_HOLD: prod_nxt = product;
      MAC_ONE:  prod_nxt = {{(PROD_W-1){1'b0}}, 1'b1};
      MAC_MUL:  prod_nxt = mul_res;
      MAC_ZERO: prod_nxt = '0;  // Overflowed request.
      default:  prod_nxt = product;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      product <= '0;
    end else begin
      product <= prod_nxt;
    end
  end

  // A multiply step must fit in the product register.
  a_mul_fits : assert property (
    @(posedge clk) disable iff (rst)
    (dp_ctrl.mac_sel == MAC_MUL) |-> (mul_full[PROD_W+OPND_W-1:PROD_W] == '0)
  ) else $error("error: mul_full %h overflows", mul_full);

endmodule

`default_nettype wire

// File: fact_rsp_buf.sv
`timescale 1ns/1ps
`default_nettype none

module fact_rsp_buf
  import fact_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst,
  input  wire dp_ctrl_t       dp_ctrl,
  input  wire [PROD_W-1:0]    product,
  input  wire                 over_limit,
  output logic                rsp_valid,
  input  wire                 rsp_ready,
  output fact_rsp_t           rsp,
  output logic                slot_full
);

  logic      valid_q;
  fact_rsp_t rsp_q;

  // Set on finish, cleared once the sink takes it.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (dp_ctrl.finish) begin
      valid_q <= 1'b1;
    end else if (valid_q && rsp_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dp_ctrl.finish) begin
      rsp_q.product <= product;
      rsp_q.err     <= over_limit;
    end
  end

  assign rsp       = rsp_q;
  assign rsp_valid = valid_q;
  assign slot_full = valid_q; // Blocks new requests.

  a_rsp_stable : assert property (
    @(posedge clk) disable iff (rst)
    (rsp_valid && !rsp_ready) |=> $stable(rsp)
  ) else $error("error: rsp changed while stalled, now %h", rsp);

  // FSM must not finish into an occupied slot.
  a_no_overwrite : assert property (
    @(posedge clk) disable iff (rst)
    dp_ctrl.finish |-> !slot_full
  ) else $error("error: finish with slot_full %h", slot_full);

endmodule

`default_nettype wire

// File: fact_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fact_ctrl
  import fact_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        req_valid,
  output logic       req_ready,
  input  wire        cnt_more,
  input  wire        over_limit,
  input  wire        slot_full,
  output dp_ctrl_t   dp_ctrl
);

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    LOAD   = 3'd1,
    CHECK  = 3'd2,
    MUL    = 3'd3,
    FINISH = 3'd4
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   mul_step;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Only take work when the response slot is free.
  assign req_ready = (state == IDLE) && !slot_full;

  // One factor per cycle while the count is above one.
  assign mul_step = cnt_more && !over_limit;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (req_valid && req_ready) begin
          state_nxt = LOAD;
        end
      end
      LOAD:   state_nxt = CHECK;
      CHECK: begin
        if (over_limit || !cnt_more) begin
          state_nxt = FINISH; // Overflow, 0! or 1!.
        end else begin
          state_nxt = MUL;
        end
      end
      MUL: begin
        if (!cnt_more) begin
          state_nxt = FINISH;
        end
      end
      FINISH: state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_comb begin
    dp_ctrl.cnt_load = 1'b0;
    dp_ctrl.cnt_dec  = 1'b0;
    dp_ctrl.mac_sel  = MAC_HOLD;
    dp_ctrl.finish   = 1'b0;
    case (state)
      LOAD: begin
        dp_ctrl.cnt_load = 1'b1;
        dp_ctrl.mac_sel  = MAC_ONE;
      end
      CHECK, MUL: begin
        if (over_limit) begin
          dp_ctrl.mac_sel = MAC_ZERO;
        end else if (mul_step) begin
          dp_ctrl.mac_sel = MAC_MUL;
          dp_ctrl.cnt_dec = 1'b1;
        end
      end
      FINISH: dp_ctrl.finish = 1'b1;
      default: ;
    endcase
  end

  a_state_legal : assert property (
    @(posedge clk) disable iff (rst)
    state inside {IDLE, LOAD, CHECK, MUL, FINISH}
  ) else $error("error: state illegal %h", state);

endmodule

`default_nettype wire

// File: fact_top.sv
`timescale 1ns/1ps
`default_nettype none

module fact_top
  import fact_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              req_valid,
  output logic             req_ready,
  input  wire fact_req_t   req,
  output logic             rsp_valid,
  input  wire              rsp_ready,
  output fact_rsp_t        rsp
);

  dp_ctrl_t          dp_ctrl;
  logic [OPND_W-1:0] count;
  logic              cnt_more;
  logic              over_limit;
  logic              slot_full;
  logic [PROD_W-1:0] product;

  fact_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .cnt_more   (cnt_more),
    .over_limit (over_limit),
    .slot_full  (slot_full),
    .dp_ctrl    (dp_ctrl)
  );

  fact_count u_count (
    .clk        (clk),
    .rst        (rst),
    .dp_ctrl    (dp_ctrl),
    .req        (req),
    .count      (count),
    .cnt_more   (cnt_more),
    .over_limit (over_limit)
  );

  fact_mac u_mac (
    .clk     (clk),
    .rst     (rst),
    .dp_ctrl (dp_ctrl),
    .count   (count),
    .product (product)
  );

  fact_rsp_buf u_rsp_buf (
    .clk        (clk),
    .rst        (rst),
    .dp_ctrl    (dp_ctrl),
    .product    (product),
    .over_limit (over_limit),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .slot_full  (slot_full)
  );

endmodule

`default_nettype wire

// File: tb_fact.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fact
  import fact_pkg::*;
();

  localparam int CLK_NS      = 4;
  localparam int RST_CYC     = 10;
  localparam int NUM_SWEEP   = 16;
  localparam int NUM_RAND    = 40;
  localparam int NUM_REQ     = NUM_SWEEP + NUM_RAND;
  localparam int CYC_PER_REQ = 40;
  localparam int WD_NS       = (NUM_REQ * CYC_PER_REQ + RST_CYC) * CLK_NS;

  logic      clk;
  logic      rst;
  logic      req_valid;
  logic      req_ready;
  fact_req_t req;
  logic      rsp_valid;
  logic      rsp_ready;
  fact_rsp_t rsp;

  logic      rsp_fire;
  logic      busy;      // Between accept and response transfer.
  fact_rsp_t exp_rsp;
  int        q_size;
  int        err_cnt;
  int        acc_cnt;
  int        rsp_cnt;
  logic [15:0] lfsr;

  logic [OPND_W-1:0] pend_q[$];

  fact_top u_fact_top (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  assign rsp_fire = rsp_valid && rsp_ready;

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [7:0] rand_bits(input int nbits);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  // Factorial by a plain loop; zero with err once n! leaves 32 bits.
  function automatic fact_rsp_t ref_fact(input logic [OPND_W-1:0] n);
    fact_rsp_t r;
    logic [PROD_W-1:0] p;
    p = 1;
    if (n > N_LIMIT) begin
      r.product = '0;
      r.err     = 1'b1;
    end else begin
      for (int i = 2; i <= n; i++) begin
        p = p * i;
      end
      r.product = p;
      r.err     = 1'b0;
    end
    return r;
  endfunction

  // Called 1 ns after a rising edge.
  task automatic send_req(input logic [OPND_W-1:0] n);
    req_valid = 1'b1;
    req.n     = n;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    req.n     = ~n; // Operand must already be captured.
  endtask

  // Scoreboard of accepted operands.
  always @(posedge clk) begin
    if (rst) begin
      pend_q.delete();
      busy    = 1'b0;
      exp_rsp = '0;
      q_size  = 0;
    end else begin
      if (rsp_fire) begin
        if (pend_q.size() > 0) begin
          void'(pend_q.pop_front());
        end
        rsp_cnt++;
        busy = 1'b0;
      end
      if (req_valid && req_ready) begin
        pend_q.push_back(req.n);
        acc_cnt++;
        busy = 1'b1;
      end
      q_size = pend_q.size();
      if (q_size > 0) begin
        exp_rsp = ref_fact(pend_q[0]);
      end
    end
  end

  always @(posedge clk) begin
    #1;
    rsp_ready = (rand_bits(2) != 2'b00); // Ready three cycles in four.
  end

  a_rsp_order : assert property (
    @(posedge clk) disable iff (rst)
    rsp_fire |-> (q_size == 1)
  ) else begin
    err_cnt++;
    $display("response transferred with no accepted request pending");
  end

  a_one_pending : assert property (
    @(posedge clk) disable iff (rst)
    q_size <= 1
  ) else begin
    err_cnt++;
    $display("more than one request in flight");
  end

  a_fact_product : assert property (
    @(posedge clk) disable iff (rst)
    (rsp_fire && !exp_rsp.err) |-> (rsp.product == exp_rsp.product)
  ) else begin
    err_cnt++;
    $display("error: rsp.product %h, expected %h",
             $sampled(rsp.product), $sampled(exp_rsp.product));
  end

  a_fact_no_err : assert property (
    @(posedge clk) disable iff (rst)
    (rsp_fire && !exp_rsp.err) |-> !rsp.err
  ) else begin
    err_cnt++;
    $display("error: rsp.err %h, expected %h", $sampled(rsp.err), 1'b0);
  end

  a_ovf_err : assert property (
    @(posedge clk) disable iff (rst)
    (rsp_fire && exp_rsp.err) |-> rsp.err
  ) else begin
    err_cnt++;
    $display("error: rsp.err %h, expected %h", $sampled(rsp.err), 1'b1);
  end

  a_ovf_zero : assert property (
    @(posedge clk) disable iff (rst)
    (rsp_fire && exp_rsp.err) |-> (rsp.product == '0)
  ) else begin
    err_cnt++;
    $display("error: rsp.product %h, expected %h", $sampled(rsp.product), 32'h0);
  end

  a_hold_rsp : assert property (
    @(posedge clk) disable iff (rst)
    (rsp_valid && !rsp_ready) |=> ($stable(rsp) && rsp_valid)
  ) else begin
    err_cnt++;
    $display("response dropped or changed while the sink stalled");
  end

  a_no_accept_stalled : assert property (
    @(posedge clk) disable iff (rst)
    (rsp_valid && !rsp_ready) |-> !req_ready
  ) else begin
    err_cnt++;
    $display("error: req_ready %h while response stalled", $sampled(req_ready));
  end

  a_busy_blocks : assert property (
    @(posedge clk) disable iff (rst)
    busy |-> !req_ready
  ) else begin
    err_cnt++;
    $display("error: req_ready %h with a request in flight", $sampled(req_ready));
  end

  // Idle and ready during reset and on the first cycle after.
  a_reset_idle : assert property (
    @(posedge clk)
    (rst || $fell(rst)) |-> (!rsp_valid && req_ready)
  ) else begin
    err_cnt++;
    $display("error: rsp_valid %h req_ready %h after reset",
             $sampled(rsp_valid), $sampled(req_ready));
  end

  initial begin
    #WD_NS;
    $display("timeout: run stopped after %0d ns, errors %0d, %0d accepted, %0d responses",
             WD_NS, err_cnt, acc_cnt, rsp_cnt);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    logic [OPND_W-1:0] op;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    err_cnt   = 0;
    acc_cnt   = 0;
    rsp_cnt   = 0;
    lfsr      = 16'd29740;
    repeat (RST_CYC) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;

    for (int n = 0; n < NUM_SWEEP; n++) begin
      send_req(OPND_W'(n));
    end
    for (int i = 0; i < NUM_RAND; i++) begin
      @(negedge clk); // Away from the rsp_ready draw.
      op = OPND_W'(rand_bits(OPND_W));
      @(posedge clk);
      #1;
      send_req(op);
    end

    // Drain the last response.
    while (q_size != 0 || rsp_valid) @(posedge clk);
    repeat (4) @(posedge clk);

    if (acc_cnt != rsp_cnt) begin
      err_cnt++;
      $display("error: rsp count %h, expected %h", rsp_cnt, acc_cnt);
    end
    $display("errors %0d, accepted %0d, responses %0d", err_cnt, acc_cnt, rsp_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
fact_pkg.sv
fact_count.sv
fact_mac.sv
fact_rsp_buf.sv
fact_ctrl.sv
fact_top.sv
tb_fact.sv
